// File: mmio_pkg.sv
/*
 * Peripheral page definitions for the native MMIO bus.
 * Address map, widths, bus and access structs, strap and GPIO pin bundles,
 * and the byte-strobe merge shared by the register blocks.
 */
package mmio_pkg;

  localparam int DATA_W    = 32;
  localparam int ADDR_W    = 32;
  localparam int STRB_W    = 4;
  localparam int GPIO_W    = 16;
  localparam int TIM_CFG_W = 3;

  // upper address bits of the page at 0x0300_00xx
  localparam logic [23:0] MMIO_PAGE = 24'h0300_00;

  localparam logic [7:0] OFS_GPIO     = 8'h00;
  localparam logic [7:0] OFS_GPIO_OEB = 8'h04;
  localparam logic [7:0] OFS_GPIO_PU  = 8'h08;
  localparam logic [7:0] OFS_GPIO_PD  = 8'h0c;
  localparam logic [7:0] OFS_CONFIG   = 8'h18;
  localparam logic [7:0] OFS_XTAL     = 8'h1c;
  localparam logic [7:0] OFS_PLL      = 8'h20;
  localparam logic [7:0] OFS_MFGR     = 8'h24;
  localparam logic [7:0] OFS_PROD     = 8'h28;
  localparam logic [7:0] OFS_MASK     = 8'h2c;
  localparam logic [7:0] OFS_CLKSEL   = 8'h30;
  localparam logic [7:0] OFS_TIM_CFG  = 8'h5c;
  localparam logic [7:0] OFS_TIM_VAL  = 8'h60;
  localparam logic [7:0] OFS_TIM_DAT  = 8'h64;

  // timer config bits
  localparam int TIM_EN     = 0;
  localparam int TIM_CONT   = 1;
  localparam int TIM_IRQ_EN = 2;

  typedef enum logic [4:0] {
    REG_NONE,
    REG_GPIO,
    REG_GPIO_OEB,
    REG_GPIO_PU,
    REG_GPIO_PD,
    REG_CONFIG,
    REG_XTAL,
    REG_PLL,
    REG_MFGR,
    REG_PROD,
    REG_MASK,
    REG_CLKSEL,
    REG_TIM_CFG,
    REG_TIM_VAL,
    REG_TIM_DAT
  } reg_id_e;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } mmio_req_t;

  // single-cycle register access after decode
  typedef struct packed {
    logic              access;
    reg_id_e           reg_id;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } mmio_access_t;

  // config is a reserved word, hence config_byte
  typedef struct packed {
    logic [7:0]  config_byte;
    logic        xtal_ena;
    logic        reg_ena;
    logic        pll_cp_ena;
    logic        pll_vco_ena;
    logic        pll_bias_ena;
    logic [3:0]  pll_trim;
    logic [11:0] mfgr_id;
    logic [7:0]  prod_id;
    logic [3:0]  mask_rev;
    logic        clk_ext_sel;
  } strap_t;

  typedef struct packed {
    logic [GPIO_W-1:0] out;
    logic [GPIO_W-1:0] outenb;
    logic [GPIO_W-1:0] pullupb;
    logic [GPIO_W-1:0] pulldownb;
  } gpio_pins_t;

  // replace each byte of old_val whose strobe bit is set
  function automatic logic [DATA_W-1:0] strb_merge(
    input logic [DATA_W-1:0] old_val,
    input logic [DATA_W-1:0] new_val,
    input logic [STRB_W-1:0] strb
  );
    logic [DATA_W-1:0] res;
    res = old_val;
    for (int i = 0; i < STRB_W; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

endpackage

// File: mmio_decode.sv
/*
 * MMIO request decode.
 * Matches the peripheral page, maps the offset to a register id and
 * issues one access strobe per held bus request.
 */
`timescale 1ns/1ps

module mmio_decode (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  mmio_pkg::mmio_req_t    req_i,
  input  logic                  ready_i,
  output mmio_pkg::mmio_access_t acc_o
);
  import mmio_pkg::*;

  logic    in_page;
  reg_id_e reg_id;

  assign in_page = (req_i.addr[ADDR_W-1:8] == MMIO_PAGE);

  always_comb begin
    case (req_i.addr[7:0])
      OFS_GPIO:     reg_id = REG_GPIO;
      OFS_GPIO_OEB: reg_id = REG_GPIO_OEB;
      OFS_GPIO_PU:  reg_id = REG_GPIO_PU;
      OFS_GPIO_PD:  reg_id = REG_GPIO_PD;
      OFS_CONFIG:   reg_id = REG_CONFIG;
      OFS_XTAL:     reg_id = REG_XTAL;
      OFS_PLL:      reg_id = REG_PLL;
      OFS_MFGR:     reg_id = REG_MFGR;
      OFS_PROD:     reg_id = REG_PROD;
      OFS_MASK:     reg_id = REG_MASK;
      OFS_CLKSEL:   reg_id = REG_CLKSEL;
      OFS_TIM_CFG:  reg_id = REG_TIM_CFG;
      OFS_TIM_VAL:  reg_id = REG_TIM_VAL;
      OFS_TIM_DAT:  reg_id = REG_TIM_DAT;
      default:      reg_id = REG_NONE;
    endcase
  end

  // ready high blocks a second access for the same held request
  assign acc_o.access = req_i.valid && in_page && !ready_i;
  assign acc_o.reg_id = reg_id;
  assign acc_o.wdata  = req_i.wdata;
  assign acc_o.wstrb  = req_i.wstrb;

  a_single_access : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    acc_o.access |=> !acc_o.access
  );

  // requester holds the request until it sees ready
  a_req_held : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (req_i.valid && !ready_i) |=> (req_i.valid && $stable(req_i.addr))
  );

endmodule

// File: gpio_regs.sv
/*
 * GPIO control registers.
 * Output, output-enable-bar, pull-up-bar and pull-down-bar, 16 bits each,
 * written byte by byte through strobe bits 0 and 1.
 */
`timescale 1ns/1ps

module gpio_regs (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  mmio_pkg::mmio_access_t acc_i,
  output mmio_pkg::gpio_pins_t   pins_o
);
  import mmio_pkg::*;

  gpio_pins_t pins_q;
  logic       wr_out;
  logic       wr_oeb;
  logic       wr_pu;
  logic       wr_pd;

  // upper strobe bits fall off with the truncation to GPIO_W
  function automatic logic [GPIO_W-1:0] gpio_upd(
    input logic [GPIO_W-1:0] cur,
    input mmio_access_t      acc
  );
    logic [DATA_W-1:0] merged;
    merged = strb_merge({{(DATA_W-GPIO_W){1'b0}}, cur}, acc.wdata, acc.wstrb);
    return merged[GPIO_W-1:0];
  endfunction

  assign wr_out = acc_i.access && (acc_i.reg_id == REG_GPIO);
  assign wr_oeb = acc_i.access && (acc_i.reg_id == REG_GPIO_OEB);
  assign wr_pu  = acc_i.access && (acc_i.reg_id == REG_GPIO_PU);
  assign wr_pd  = acc_i.access && (acc_i.reg_id == REG_GPIO_PD);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pins_q.out       <= '0;
      pins_q.outenb    <= '1;  // pads start as inputs
      pins_q.pullupb   <= '0;
      pins_q.pulldownb <= '0;
    end else begin
      if (wr_out) begin
        pins_q.out <= gpio_upd(pins_q.out, acc_i);
      end
      if (wr_oeb) begin
        pins_q.outenb <= gpio_upd(pins_q.outenb, acc_i);
      end
      if (wr_pu) begin
        pins_q.pullupb <= gpio_upd(pins_q.pullupb, acc_i);
      end
      if (wr_pd) begin
        pins_q.pulldownb <= gpio_upd(pins_q.pulldownb, acc_i);
      end
    end
  end

  assign pins_o = pins_q;

  a_oeb_after_reset : assert property (
    @(posedge clk_i) $rose(rst_n_i) |-> (pins_o.outenb == '1)
  );

endmodule

// File: counter_timer.sv
/*
 * Down-counting timer.
 * Counts val toward zero while enabled, reloads from dat in continuous mode
 * or stops in one-shot mode, and raises a maskable interrupt on expiry.
 */
`timescale 1ns/1ps

module counter_timer (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  mmio_pkg::mmio_access_t          acc_i,
  output logic [mmio_pkg::TIM_CFG_W-1:0] cfg_o,
  output logic [mmio_pkg::DATA_W-1:0]    val_o,
  output logic [mmio_pkg::DATA_W-1:0]    dat_o,
  output logic                           irq_o
);
  import mmio_pkg::*;

  logic [TIM_CFG_W-1:0] cfg_q;
  logic [DATA_W-1:0]    val_q;
  logic [DATA_W-1:0]    dat_q;
  logic                 pending_q;
  logic                 cfg_we;
  logic                 val_we;
  logic                 dat_we;
  logic                 counting;
  logic                 expire;

  assign cfg_we = acc_i.access && (acc_i.reg_id == REG_TIM_CFG) && acc_i.wstrb[0];
  assign val_we = acc_i.access && (acc_i.reg_id == REG_TIM_VAL) && (|acc_i.wstrb);
  assign dat_we = acc_i.access && (acc_i.reg_id == REG_TIM_DAT) && (|acc_i.wstrb);

  assign counting = cfg_q[TIM_EN] && (val_q != '0);
  // the step from one to zero, unless a bus write overrides it
  assign expire   = cfg_q[TIM_EN] && (val_q == DATA_W'(1)) && !val_we;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q     <= '0;
      val_q     <= '0;
      dat_q     <= '0;
      pending_q <= 1'b0;
    end else begin
      if (cfg_we) begin
        cfg_q <= acc_i.wdata[TIM_CFG_W-1:0];
      end else if (expire && !cfg_q[TIM_CONT]) begin
        cfg_q[TIM_EN] <= 1'b0;
      end

      if (val_we) begin
        val_q <= strb_merge(val_q, acc_i.wdata, acc_i.wstrb);
      end else if (expire && cfg_q[TIM_CONT]) begin
        val_q <= dat_q;
      end else if (counting) begin
        val_q <= val_q - 1'b1;
      end

      if (dat_we) begin
        dat_q <= strb_merge(dat_q, acc_i.wdata, acc_i.wstrb);
      end

      // any config write acknowledges the interrupt
      if (cfg_we) begin
        pending_q <= 1'b0;
      end else if (expire) begin
        pending_q <= 1'b1;
      end
    end
  end

  assign cfg_o = cfg_q;
  assign val_o = val_q;
  assign dat_o = dat_q;
  assign irq_o = pending_q && cfg_q[TIM_IRQ_EN];

  // a raised interrupt holds until a config write acknowledges it
  a_irq_held : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (irq_o && !cfg_we) |=> irq_o
  );

  a_no_wrap : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (!cfg_q[TIM_CONT] && (val_q == '0) && !val_we) |=> (val_q == '0)
  );

endmodule

// File: mmio_resp.sv
/*
 * MMIO response path.
 * Selects read data by register id and returns it with a one-cycle
 * registered ready pulse.
 */
`timescale 1ns/1ps

module mmio_resp (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  mmio_pkg::mmio_access_t          acc_i,
  input  logic [mmio_pkg::GPIO_W-1:0]    gpio_in_i,
  input  mmio_pkg::gpio_pins_t            pins_i,
  input  mmio_pkg::strap_t                strap_i,
  input  logic [mmio_pkg::TIM_CFG_W-1:0] tim_cfg_i,
  input  logic [mmio_pkg::DATA_W-1:0]    tim_val_i,
  input  logic [mmio_pkg::DATA_W-1:0]    tim_dat_i,
  output logic                           ready_o,
  output logic [mmio_pkg::DATA_W-1:0]    rdata_o
);
  import mmio_pkg::*;

  logic [DATA_W-1:0] rd_mux;
  logic [DATA_W-1:0] rdata_q;
  logic              ready_q;

  // a write returns the value held before the same edge
  always_comb begin
    case (acc_i.reg_id)
      REG_GPIO:     rd_mux = {pins_i.out, gpio_in_i};
      REG_GPIO_OEB: rd_mux = {16'd0, pins_i.outenb};
      REG_GPIO_PU:  rd_mux = {16'd0, pins_i.pullupb};
      REG_GPIO_PD:  rd_mux = {16'd0, pins_i.pulldownb};
      REG_CONFIG:   rd_mux = {24'd0, strap_i.config_byte};
      REG_XTAL:     rd_mux = {30'd0, strap_i.xtal_ena, strap_i.reg_ena};
      REG_PLL: begin
        rd_mux = {25'd0, strap_i.pll_trim, strap_i.pll_cp_ena,
                  strap_i.pll_vco_ena, strap_i.pll_bias_ena};
      end
      REG_MFGR:     rd_mux = {20'd0, strap_i.mfgr_id};
      REG_PROD:     rd_mux = {24'd0, strap_i.prod_id};
      REG_MASK:     rd_mux = {28'd0, strap_i.mask_rev};
      REG_CLKSEL:   rd_mux = {31'd0, strap_i.clk_ext_sel};
      REG_TIM_CFG:  rd_mux = {{(DATA_W-TIM_CFG_W){1'b0}}, tim_cfg_i};
      REG_TIM_VAL:  rd_mux = tim_val_i;
      REG_TIM_DAT:  rd_mux = tim_dat_i;
      default:      rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= acc_i.access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc_i.access) begin
      rdata_q <= rd_mux;
    end
  end

  assign ready_o = ready_q;
  assign rdata_o = rdata_q;

  a_ready_pulse : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    ready_o |=> !ready_o
  );

endmodule

// File: soc_mmio_top.sv
/*
 * Peripheral page top level.
 * Connects request decode, GPIO registers, timer and response path.
 */
`timescale 1ns/1ps

module soc_mmio_top (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  mmio_pkg::mmio_req_t          req_i,
  output logic                        ready_o,
  output logic [mmio_pkg::DATA_W-1:0] rdata_o,
  input  logic [mmio_pkg::GPIO_W-1:0] gpio_in_i,
  input  mmio_pkg::strap_t             strap_i,
  output mmio_pkg::gpio_pins_t         gpio_o,
  output logic                        timer_irq_o
);
  import mmio_pkg::*;

  mmio_access_t         acc;
  logic [TIM_CFG_W-1:0] tim_cfg;
  logic [DATA_W-1:0]    tim_val;
  logic [DATA_W-1:0]    tim_dat;

  mmio_decode u_decode (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .req_i  (req_i),
    .ready_i(ready_o),
    .acc_o  (acc)
  );

  gpio_regs u_gpio (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .acc_i  (acc),
    .pins_o (gpio_o)
  );

  counter_timer u_timer (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .acc_i  (acc),
    .cfg_o  (tim_cfg),
    .val_o  (tim_val),
    .dat_o  (tim_dat),
    .irq_o  (timer_irq_o)
  );

  mmio_resp u_resp (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .acc_i    (acc),
    .gpio_in_i(gpio_in_i),
    .pins_i   (gpio_o),
    .strap_i  (strap_i),
    .tim_cfg_i(tim_cfg),
    .tim_val_i(tim_val),
    .tim_dat_i(tim_dat),
    .ready_o  (ready_o),
    .rdata_o  (rdata_o)
  );

endmodule

// File: tb_soc_mmio.sv
/*
 * Testbench for the peripheral page.
 * Acts as the CPU on the native bus and checks GPIO, straps, timer and handshake.
 */
`timescale 1ns/1ps

module tb_soc_mmio;
  import mmio_pkg::*;

  // 144 bus transactions, two one-shot/continuous timer runs of up to 44 and 24 cycles
  localparam int NUM_TRANS       = 144;
  localparam int TIMER_CYCLES    = (40 + 4) + (20 + 4);
  localparam int WATCHDOG_CYCLES = NUM_TRANS * 4 + TIMER_CYCLES + 200;

  logic              clk_i;
  logic              rst_n_i;
  mmio_req_t         req_i;
  logic              ready_o;
  logic [DATA_W-1:0] rdata_o;
  logic [GPIO_W-1:0] gpio_in_i;
  strap_t            strap_i;
  gpio_pins_t        gpio_o;
  logic              timer_irq_o;

  // shadow copies of the writable registers
  gpio_pins_t        gpio_sh;
  logic [2:0]        cfg_sh;
  logic [DATA_W-1:0] val_sh;
  logic [DATA_W-1:0] dat_sh;
  logic [DATA_W-1:0] exp_q[$];
  bit                chk_q[$];
  string             test_name  = "none";
  int                val_errs   = 0;
  int                proto_errs = 0;
  logic              ready_prev = 1'b0;

  soc_mmio_top uut (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (req_i),
    .ready_o    (ready_o),
    .rdata_o    (rdata_o),
    .gpio_in_i  (gpio_in_i),
    .strap_i    (strap_i),
    .gpio_o     (gpio_o),
    .timer_irq_o(timer_irq_o)
  );

  function automatic logic [15:0] gpio_merge(input logic [15:0] old_val,
                                             input logic [31:0] wdata, input logic [3:0] strb);
    logic [15:0] res;
    res = old_val;
    if (strb[0]) res[7:0] = wdata[7:0];
    if (strb[1]) res[15:8] = wdata[15:8];
    return res;
  endfunction

  // read layout of the strap registers, zero for anything else
  function automatic logic [31:0] strap_pack(input logic [7:0] ofs, input strap_t s);
    case (ofs)
      OFS_CONFIG: return {24'd0, s.config_byte};
      OFS_XTAL:   return {30'd0, s.xtal_ena, s.reg_ena};
      OFS_PLL:    return {25'd0, s.pll_trim, s.pll_cp_ena, s.pll_vco_ena, s.pll_bias_ena};
      OFS_MFGR:   return {20'd0, s.mfgr_id};
      OFS_PROD:   return {24'd0, s.prod_id};
      OFS_MASK:   return {28'd0, s.mask_rev};
      OFS_CLKSEL: return {31'd0, s.clk_ext_sel};
      default:    return 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] expected_read(input logic [7:0] ofs);
    case (ofs)
      OFS_GPIO:     return {gpio_sh.out, gpio_in_i};
      OFS_GPIO_OEB: return {16'd0, gpio_sh.outenb};
      OFS_GPIO_PU:  return {16'd0, gpio_sh.pullupb};
      OFS_GPIO_PD:  return {16'd0, gpio_sh.pulldownb};
      OFS_TIM_CFG:  return {29'd0, cfg_sh};
      OFS_TIM_VAL:  return val_sh;
      OFS_TIM_DAT:  return dat_sh;
      default:      return strap_pack(ofs, strap_i);
    endcase
  endfunction

  task automatic check_value(input string what, input logic [63:0] exp_val,
                             input logic [63:0] act);
    assert (act === exp_val) else begin
      val_errs++;
      $display("Fail %s: %s expected %h, actual %h", test_name, what, exp_val, act);
    end
  endtask

  // entered on a falling edge; request held through the ready cycle
  task automatic issue_request(input logic [7:0] ofs, input logic [31:0] wdata,
                               input logic [3:0] strb, input bit exact,
                               output logic [31:0] rdata);
    int waits;
    waits = 0;
    exp_q.push_back(expected_read(ofs));
    chk_q.push_back(exact);
    req_i.valid = 1'b1;
    req_i.addr  = {MMIO_PAGE, ofs};
    req_i.wdata = wdata;
    req_i.wstrb = strb;
    do begin
      @(negedge clk_i);
      waits++;
    end while (ready_o !== 1'b1);
    rdata = rdata_o;
    assert (waits == 1) else begin
      proto_errs++;
      $display("ready_o came %0d cycles after the request instead of one", waits);
    end
    @(negedge clk_i);
    req_i.valid = 1'b0;
  endtask

  task automatic bus_read(input logic [7:0] ofs, input bit exact, output logic [31:0] rdata);
    issue_request(ofs, 32'd0, 4'd0, exact, rdata);
  endtask

  // timer registers are always written with full strobes here
  task automatic bus_write(input logic [7:0] ofs, input logic [31:0] wdata,
                           input logic [3:0] strb);
    logic [31:0] old_val;
    issue_request(ofs, wdata, strb, 1'b1, old_val);
    case (ofs)
      OFS_GPIO:     gpio_sh.out       = gpio_merge(gpio_sh.out, wdata, strb);
      OFS_GPIO_OEB: gpio_sh.outenb    = gpio_merge(gpio_sh.outenb, wdata, strb);
      OFS_GPIO_PU:  gpio_sh.pullupb   = gpio_merge(gpio_sh.pullupb, wdata, strb);
      OFS_GPIO_PD:  gpio_sh.pulldownb = gpio_merge(gpio_sh.pulldownb, wdata, strb);
      OFS_TIM_CFG:  if (strb[0]) cfg_sh = wdata[2:0];
      OFS_TIM_VAL:  val_sh = wdata;
      OFS_TIM_DAT:  dat_sh = wdata;
      default: ;
    endcase
  endtask

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // compare every ready cycle against the value queued with its request
  always @(negedge clk_i) begin : compare
    logic [31:0] exp_val;
    bit          exact;
    if (rst_n_i && ready_o) begin
      assert (exp_q.size() > 0) else begin
        proto_errs++;
        $display("ready_o went high with no request outstanding");
      end
      if (exp_q.size() > 0) begin
        exp_val = exp_q.pop_front();
        exact   = chk_q.pop_front();
        if (exact) begin
          assert (rdata_o === exp_val) else begin
            val_errs++;
            $display("Fail %s: expected %h, actual %h", test_name, exp_val, rdata_o);
          end
        end
      end
    end
    assert (!(ready_o && ready_prev)) else begin
      proto_errs++;
      $display("ready_o stayed high for two cycles in a row");
    end
    ready_prev = ready_o;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("the run timed out after %0d cycles", WATCHDOG_CYCLES);
    $display("errors: value %0d, protocol %0d", val_errs, proto_errs);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] rd;
    logic [63:0] rnd;
    logic [7:0]  ofs;
    int          n;
    int          w;
    void'($urandom(32'h4fd5e9cb));
    rst_n_i   = 1'b0;
    req_i     = '0;
    gpio_in_i = '0;
    strap_i   = '0;
    gpio_sh   = {16'h0000, 16'hffff, 16'h0000, 16'h0000};
    cfg_sh    = '0;
    val_sh    = '0;
    dat_sh    = '0;
    repeat (8) @(negedge clk_i);
    rst_n_i = 1'b1;

    test_name = "reset";
    check_value("gpio_o", gpio_sh, gpio_o);
    check_value("ready_o", 1'b0, ready_o);
    check_value("timer_irq_o", 1'b0, timer_irq_o);
    bus_read(OFS_TIM_CFG, 1'b1, rd);
    bus_read(OFS_TIM_VAL, 1'b1, rd);
    bus_read(OFS_TIM_DAT, 1'b1, rd);

    test_name = "gpio";
    for (int i = 0; i < 40; i++) begin
      ofs = 8'(($urandom % 4) * 4);
      bus_write(ofs, $urandom, 4'($urandom));
      check_value("gpio_o", gpio_sh, gpio_o);
      gpio_in_i = 16'($urandom);
      bus_read(8'(($urandom % 4) * 4), 1'b1, rd);
    end

    test_name = "strap";
    for (int i = 0; i < 4; i++) begin
      rnd = {$urandom, $urandom};
      strap_i = rnd[$bits(strap_t)-1:0];
      for (int k = 0; k < 7; k++) begin
        bus_read(8'(OFS_CONFIG + 4 * k), 1'b1, rd);
      end
    end

    // gaps above the timer answer with zero and hold no state
    test_name = "unmapped";
    for (int k = 0; k < 6; k++) begin
      ofs = 8'(8'h68 + 8'h14 * k);
      bus_write(ofs, $urandom, 4'hf);
      bus_read(ofs, 1'b1, rd);
    end
    check_value("gpio_o", gpio_sh, gpio_o);
    bus_read(OFS_TIM_CFG, 1'b1, rd);
    bus_read(OFS_TIM_VAL, 1'b1, rd);
    bus_read(OFS_TIM_DAT, 1'b1, rd);

    test_name = "oneshot";
    n = 5 + $urandom % 36;
    bus_write(OFS_TIM_DAT, n, 4'hf);
    bus_write(OFS_TIM_VAL, n, 4'hf);
    bus_write(OFS_TIM_CFG, 32'h5, 4'h1);
    w = 0;
    while (timer_irq_o !== 1'b1 && w < n + 4) begin
      @(negedge clk_i);
      w++;
    end
    assert (timer_irq_o === 1'b1) else begin
      proto_errs++;
      $display("timer_irq_o did not rise within %0d cycles", n + 4);
    end
    val_sh = '0;
    cfg_sh = 3'b100;
    bus_read(OFS_TIM_VAL, 1'b1, rd);
    bus_read(OFS_TIM_CFG, 1'b1, rd);
    bus_write(OFS_TIM_CFG, 32'h4, 4'h1);
    check_value("timer_irq_o", 1'b0, timer_irq_o);

    test_name = "continuous";
    n = 5 + $urandom % 16;
    bus_write(OFS_TIM_DAT, n, 4'hf);
    bus_write(OFS_TIM_VAL, n, 4'hf);
    bus_write(OFS_TIM_CFG, 32'h3, 4'h1);
    repeat (n + 4) @(negedge clk_i);
    for (int k = 0; k < 8; k++) begin
      bus_read(OFS_TIM_VAL, 1'b0, rd);
      assert (rd >= 1 && rd <= n) else begin
        val_errs++;
        $display("Fail %s: expected val in 1..%0d, actual %0d", test_name, n, rd);
      end
      check_value("timer_irq_o", 1'b0, timer_irq_o);
    end
    bus_read(OFS_TIM_CFG, 1'b1, rd);

    repeat (4) @(negedge clk_i);
    $display("errors: value %0d, protocol %0d", val_errs, proto_errs);
    if (val_errs == 0 && proto_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: files.f
mmio_pkg.sv
mmio_decode.sv
gpio_regs.sv
counter_timer.sv
mmio_resp.sv
soc_mmio_top.sv
tb_soc_mmio.sv
